// File: disp_timing_pkg.sv
package disp_timing_pkg;

    // Horizontal raster in pixel clocks
    localparam int H_ACTIVE = 40;
    localparam int H_FRONT  = 2;
    localparam int H_SYNC   = 4;
    localparam int H_BACK   = 2;
    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

    // Vertical raster in lines
    localparam int V_ACTIVE = 30;
    localparam int V_FRONT  = 1;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 1;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    // Sync windows, active high
    localparam int HS_START = H_ACTIVE + H_FRONT;
    localparam int HS_END   = HS_START + H_SYNC;
    localparam int VS_START = V_ACTIVE + V_FRONT;
    localparam int VS_END   = VS_START + V_SYNC;

    // Stored image, each pixel shown as SCALE x SCALE
    localparam int FB_WIDTH    = 16;
    localparam int FB_HEIGHT   = 12;
    localparam int SCALE       = 2;
    localparam int SCALE_SHIFT = 1;
    localparam int REGION_W    = FB_WIDTH * SCALE;
    localparam int REGION_H    = FB_HEIGHT * SCALE;

    localparam int FB_DEPTH  = FB_WIDTH * FB_HEIGHT;
    localparam int FB_ADDR_W = 8;
    localparam int COORD_W   = 8;

endpackage

// File: disp_pix_pkg.sv
package disp_pix_pkg;

    localparam int COLOR_IDX_W = 4;
    localparam int PAL_ENTRIES = 16;
    localparam int CHAN_W      = 4;
    localparam int DEPTH_W     = 12;
    localparam int PAL_W       = 3 * CHAN_W;

    typedef logic [COLOR_IDX_W-1:0] color_idx_t;
    typedef logic [DEPTH_W-1:0]     depth_t;

    // Far plane, so any real pixel passes the test
    localparam depth_t     DEPTH_CLEAR = '1;
    localparam color_idx_t FB_CLEAR    = '0;

    typedef struct packed {
        logic [CHAN_W-1:0] red;
        logic [CHAN_W-1:0] green;
        logic [CHAN_W-1:0] blue;
    } pal_rgb_t;

    // Written as a raw word, read back as channels
    typedef union packed {
        logic [PAL_W-1:0] raw;
        pal_rgb_t         rgb;
    } pal_entry_u;

endpackage

// File: video_timing.sv
`timescale 1ns/100ps

module video_timing (
    input  logic                                clk,
    input  logic                                rstn,
    output logic [disp_timing_pkg::COORD_W-1:0] o_sx,
    output logic [disp_timing_pkg::COORD_W-1:0] o_sy,
    output logic                                o_hsync,
    output logic                                o_vsync,
    output logic                                o_de,
    output logic                                o_frame
);
    import disp_timing_pkg::*;

    logic [COORD_W-1:0] sx_next;
    logic [COORD_W-1:0] sy_next;

    always_comb begin
        sx_next = o_sx + 1'b1;
        sy_next = o_sy;
        if (o_sx == COORD_W'(H_TOTAL - 1)) begin
            sx_next = '0;
            if (o_sy == COORD_W'(V_TOTAL - 1)) begin
                sy_next = '0;
            end else begin
                sy_next = o_sy + 1'b1;
            end
        end
    end

    // Flags decoded from the next count so they line up with the counters
    always_ff @(posedge clk) begin
        if (!rstn) begin
            // Last position of the frame, so (0,0) follows reset
            o_sx    <= COORD_W'(H_TOTAL - 1);
            o_sy    <= COORD_W'(V_TOTAL - 1);
            o_hsync <= 1'b0;
            o_vsync <= 1'b0;
            o_de    <= 1'b0;
            o_frame <= 1'b0;
        end else begin
            o_sx    <= sx_next;
            o_sy    <= sy_next;
            o_hsync <= (sx_next >= COORD_W'(HS_START)) && (sx_next < COORD_W'(HS_END));
            o_vsync <= (sy_next >= COORD_W'(VS_START)) && (sy_next < COORD_W'(VS_END));
            o_de    <= (sx_next < COORD_W'(H_ACTIVE)) && (sy_next < COORD_W'(V_ACTIVE));
            // Start of vertical blanking
            o_frame <= (sx_next == '0) && (sy_next == COORD_W'(V_ACTIVE));
        end
    end

endmodule

// File: pixel_ram.sv
`timescale 1ns/100ps

module pixel_ram #(
    parameter type data_t = logic
) (
    input  logic                                  clk,
    input  logic                                  rstn,
    input  logic                                  i_clear,
    input  data_t                                 i_clear_value,
    input  logic                                  i_we,
    input  logic [disp_timing_pkg::FB_ADDR_W-1:0] i_waddr,
    input  data_t                                 i_wdata,
    input  logic [disp_timing_pkg::FB_ADDR_W-1:0] i_raddr,
    output data_t                                 o_rdata,
    output logic                                  o_ready
);
    import disp_timing_pkg::*;

    data_t              mem [FB_DEPTH];
    logic               clearing;
    logic [FB_ADDR_W-1:0] clr_addr;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            clearing <= 1'b0;
            clr_addr <= '0;
        end else if (clearing) begin
            clr_addr <= clr_addr + 1'b1;
            if (clr_addr == FB_ADDR_W'(FB_DEPTH - 1)) begin
                clearing <= 1'b0;
            end
        end else if (i_clear) begin
            clearing <= 1'b1;
            clr_addr <= '0;
        end
    end

    // Sweep owns the write port, normal writes are dropped
    always_ff @(posedge clk) begin
        if (clearing) begin
            mem[clr_addr] <= i_clear_value;
        end else if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
        o_rdata <= mem[i_raddr];
    end

    assign o_ready = ~clearing;

endmodule

// File: depth_write.sv
`timescale 1ns/100ps

module depth_write (
    input  logic                                  clk,
    input  logic                                  rstn,
    input  logic                                  i_pix_valid,
    input  logic [disp_timing_pkg::FB_ADDR_W-1:0] i_pix_addr,
    input  disp_pix_pkg::color_idx_t              i_pix_color,
    input  disp_pix_pkg::depth_t                  i_pix_depth,
    input  disp_pix_pkg::depth_t                  i_stored_depth,
    input  logic                                  i_ready,
    output logic                                  o_we,
    output logic [disp_timing_pkg::FB_ADDR_W-1:0] o_waddr,
    output disp_pix_pkg::color_idx_t              o_wcolor,
    output disp_pix_pkg::depth_t                  o_wdepth
);
    import disp_timing_pkg::*;
    import disp_pix_pkg::*;

    logic                 valid_q;
    logic [FB_ADDR_W-1:0] addr_q;
    color_idx_t           color_q;
    depth_t               depth_q;

    // Write from last cycle, not yet visible on the RAM read
    logic                 last_we;
    logic [FB_ADDR_W-1:0] last_addr;
    depth_t               last_depth;
    depth_t               cmp_depth;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= 1'b0;
            last_we <= 1'b0;
        end else begin
            valid_q <= i_pix_valid & i_ready;
            last_we <= o_we;
        end
        addr_q     <= i_pix_addr;
        color_q    <= i_pix_color;
        depth_q    <= i_pix_depth;
        last_addr  <= o_waddr;
        last_depth <= o_wdepth;
    end

    assign cmp_depth = (last_we && last_addr == addr_q) ? last_depth : i_stored_depth;

    assign o_we     = valid_q & i_ready & (depth_q < cmp_depth);
    assign o_waddr  = addr_q;
    assign o_wcolor = color_q;
    assign o_wdepth = depth_q;

endmodule

// File: frame_swap_ctrl.sv
`timescale 1ns/100ps

module frame_swap_ctrl (
    input  logic clk,
    input  logic rstn,
    input  logic i_render_done,
    input  logic i_frame,
    output logic o_render_sel,
    output logic o_frame_swapped
);

    logic done_q;
    logic swap_now;

    assign swap_now = i_frame & done_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            done_q          <= 1'b0;
            o_render_sel    <= 1'b0;
            o_frame_swapped <= 1'b0;
        end else begin
            // A new done in the swap cycle stays pending for the next frame
            if (i_render_done) begin
                done_q <= 1'b1;
            end else if (swap_now) begin
                done_q <= 1'b0;
            end

            if (swap_now) begin
                o_render_sel <= ~o_render_sel;
            end
            o_frame_swapped <= swap_now;
        end
    end

endmodule

// File: palette_regs.sv
`timescale 1ns/100ps

module palette_regs (
    input  logic                             clk,
    input  logic                             rstn,
    input  logic                             i_pal_we,
    input  disp_pix_pkg::color_idx_t         i_pal_idx,
    input  logic [disp_pix_pkg::PAL_W-1:0]   i_pal_data,
    input  disp_pix_pkg::color_idx_t         i_rd_idx,
    output disp_pix_pkg::pal_entry_u         o_rd_entry
);
    import disp_pix_pkg::*;

    pal_entry_u pal [PAL_ENTRIES];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < PAL_ENTRIES; i++) begin
                pal[i].raw <= '0;
            end
        end else if (i_pal_we) begin
            pal[i_pal_idx].raw <= i_pal_data;
        end
    end

    // Lookup sits in the scan-out stage 2 path
    assign o_rd_entry = pal[i_rd_idx];

endmodule

// File: scan_out.sv
`timescale 1ns/100ps

module scan_out (
    input  logic                                  clk,
    input  logic                                  rstn,
    input  logic [disp_timing_pkg::COORD_W-1:0]   i_sx,
    input  logic [disp_timing_pkg::COORD_W-1:0]   i_sy,
    input  logic                                  i_hsync,
    input  logic                                  i_vsync,
    input  logic                                  i_de,
    input  disp_pix_pkg::color_idx_t              i_fb_rdata,
    input  disp_pix_pkg::pal_entry_u              i_pal_entry,
    output logic [disp_timing_pkg::FB_ADDR_W-1:0] o_fb_raddr,
    output disp_pix_pkg::color_idx_t              o_pal_idx,
    output logic                                  o_hsync,
    output logic                                  o_vsync,
    output logic                                  o_de,
    output logic [disp_pix_pkg::CHAN_W-1:0]       o_red,
    output logic [disp_pix_pkg::CHAN_W-1:0]       o_green,
    output logic [disp_pix_pkg::CHAN_W-1:0]       o_blue
);
    import disp_timing_pkg::*;
    import disp_pix_pkg::*;

    logic [COORD_W-1:0] fb_x;
    logic [COORD_W-1:0] fb_y;
    logic               in_region;
    logic               in_region_q;
    logic               hsync_q;
    logic               vsync_q;
    logic               de_q;

    // Stage 1: address goes straight to the RAM, which registers it
    assign fb_x       = i_sx >> SCALE_SHIFT;
    assign fb_y       = i_sy >> SCALE_SHIFT;
    assign o_fb_raddr = FB_ADDR_W'(fb_y * FB_WIDTH + fb_x);
    assign in_region  = (i_sx < COORD_W'(REGION_W)) && (i_sy < COORD_W'(REGION_H));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            in_region_q <= 1'b0;
            hsync_q     <= 1'b0;
            vsync_q     <= 1'b0;
            de_q        <= 1'b0;
        end else begin
            in_region_q <= in_region;
            hsync_q     <= i_hsync;
            vsync_q     <= i_vsync;
            de_q        <= i_de;
        end
    end

    // Stage 2: RAM data indexes the palette
    assign o_pal_idx = i_fb_rdata;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_hsync <= 1'b0;
            o_vsync <= 1'b0;
            o_de    <= 1'b0;
            o_red   <= '0;
            o_green <= '0;
            o_blue  <= '0;
        end else begin
            o_hsync <= hsync_q;
            o_vsync <= vsync_q;
            o_de    <= de_q;
            if (de_q && in_region_q) begin
                o_red   <= i_pal_entry.rgb.red;
                o_green <= i_pal_entry.rgb.green;
                o_blue  <= i_pal_entry.rgb.blue;
            end else begin
                o_red   <= '0;
                o_green <= '0;
                o_blue  <= '0;
            end
        end
    end

endmodule

// File: display_top.sv
`timescale 1ns/100ps

module display_top (
    input  logic                                  clk,
    input  logic                                  rstn,
    input  logic                                  i_pix_valid,
    input  logic [disp_timing_pkg::FB_ADDR_W-1:0] i_pix_addr,
    input  disp_pix_pkg::color_idx_t              i_pix_color,
    input  disp_pix_pkg::depth_t                  i_pix_depth,
    input  logic                                  i_frame_clear,
    input  logic                                  i_render_done,
    input  logic                                  i_pal_we,
    input  disp_pix_pkg::color_idx_t              i_pal_idx,
    input  logic [disp_pix_pkg::PAL_W-1:0]        i_pal_data,
    output logic                                  o_render_ready,
    output logic                                  o_frame_swapped,
    output logic                                  o_hsync,
    output logic                                  o_vsync,
    output logic                                  o_de,
    output logic [disp_pix_pkg::CHAN_W-1:0]       o_red,
    output logic [disp_pix_pkg::CHAN_W-1:0]       o_green,
    output logic [disp_pix_pkg::CHAN_W-1:0]       o_blue
);
    import disp_timing_pkg::*;
    import disp_pix_pkg::*;

    logic [COORD_W-1:0]   sx;
    logic [COORD_W-1:0]   sy;
    logic                 vt_hsync;
    logic                 vt_vsync;
    logic                 vt_de;
    logic                 frame;
    logic                 render_sel;

    logic                 dw_we;
    logic [FB_ADDR_W-1:0] dw_waddr;
    color_idx_t           dw_wcolor;
    depth_t               dw_wdepth;
    depth_t               db_rdata;
    logic                 db_ready;
    logic                 wr_ready;

    logic                 fb_a_we;
    logic                 fb_b_we;
    logic                 fb_a_clear;
    logic                 fb_b_clear;
    logic                 fb_a_ready;
    logic                 fb_b_ready;
    color_idx_t           fb_a_rdata;
    color_idx_t           fb_b_rdata;
    color_idx_t           scan_rdata;
    logic [FB_ADDR_W-1:0] scan_raddr;
    color_idx_t           pal_idx;
    pal_entry_u           pal_entry;

    video_timing u_timing (
        .clk     (clk),
        .rstn    (rstn),
        .o_sx    (sx),
        .o_sy    (sy),
        .o_hsync (vt_hsync),
        .o_vsync (vt_vsync),
        .o_de    (vt_de),
        .o_frame (frame)
    );

    frame_swap_ctrl u_swap (
        .clk             (clk),
        .rstn            (rstn),
        .i_render_done   (i_render_done),
        .i_frame         (frame),
        .o_render_sel    (render_sel),
        .o_frame_swapped (o_frame_swapped)
    );

    // Render target takes writes and clears, the other one is scanned out
    always_comb begin
        fb_a_we        = dw_we & ~render_sel;
        fb_b_we        = dw_we & render_sel;
        fb_a_clear     = i_frame_clear & ~render_sel;
        fb_b_clear     = i_frame_clear & render_sel;
        o_render_ready = render_sel ? fb_b_ready : fb_a_ready;
        scan_rdata     = render_sel ? fb_a_rdata : fb_b_rdata;
    end

    assign wr_ready = o_render_ready & db_ready;

    depth_write u_depth_write (
        .clk            (clk),
        .rstn           (rstn),
        .i_pix_valid    (i_pix_valid),
        .i_pix_addr     (i_pix_addr),
        .i_pix_color    (i_pix_color),
        .i_pix_depth    (i_pix_depth),
        .i_stored_depth (db_rdata),
        .i_ready        (wr_ready),
        .o_we           (dw_we),
        .o_waddr        (dw_waddr),
        .o_wcolor       (dw_wcolor),
        .o_wdepth       (dw_wdepth)
    );

    pixel_ram #(.data_t(depth_t)) depth_buf (
        .clk           (clk),
        .rstn          (rstn),
        .i_clear       (i_frame_clear),
        .i_clear_value (DEPTH_CLEAR),
        .i_we          (dw_we),
        .i_waddr       (dw_waddr),
        .i_wdata       (dw_wdepth),
        .i_raddr       (i_pix_addr),
        .o_rdata       (db_rdata),
        .o_ready       (db_ready)
    );

    pixel_ram #(.data_t(color_idx_t)) fb_a (
        .clk           (clk),
        .rstn          (rstn),
        .i_clear       (fb_a_clear),
        .i_clear_value (FB_CLEAR),
        .i_we          (fb_a_we),
        .i_waddr       (dw_waddr),
        .i_wdata       (dw_wcolor),
        .i_raddr       (scan_raddr),
        .o_rdata       (fb_a_rdata),
        .o_ready       (fb_a_ready)
    );

    pixel_ram #(.data_t(color_idx_t)) fb_b (
        .clk           (clk),
        .rstn          (rstn),
        .i_clear       (fb_b_clear),
        .i_clear_value (FB_CLEAR),
        .i_we          (fb_b_we),
        .i_waddr       (dw_waddr),
        .i_wdata       (dw_wcolor),
        .i_raddr       (scan_raddr),
        .o_rdata       (fb_b_rdata),
        .o_ready       (fb_b_ready)
    );

    palette_regs u_palette (
        .clk        (clk),
        .rstn       (rstn),
        .i_pal_we   (i_pal_we),
        .i_pal_idx  (i_pal_idx),
        .i_pal_data (i_pal_data),
        .i_rd_idx   (pal_idx),
        .o_rd_entry (pal_entry)
    );

    scan_out u_scan (
        .clk         (clk),
        .rstn        (rstn),
        .i_sx        (sx),
        .i_sy        (sy),
        .i_hsync     (vt_hsync),
        .i_vsync     (vt_vsync),
        .i_de        (vt_de),
        .i_fb_rdata  (scan_rdata),
        .i_pal_entry (pal_entry),
        .o_fb_raddr  (scan_raddr),
        .o_pal_idx   (pal_idx),
        .o_hsync     (o_hsync),
        .o_vsync     (o_vsync),
        .o_de        (o_de),
        .o_red       (o_red),
        .o_green     (o_green),
        .o_blue      (o_blue)
    );

endmodule

// File: tb_display.sv
`timescale 1ns/100ps

module tb_display;
    import disp_timing_pkg::*;
    import disp_pix_pkg::*;

    localparam int CLK_PERIOD  = 4;
    // Reset, four swaps, five frame checks and the write phases fit well inside this
    localparam int TEST_FRAMES = 24;
    localparam int WATCHDOG_NS = TEST_FRAMES * H_TOTAL * V_TOTAL * CLK_PERIOD;

    logic                 clk;
    logic                 rstn;
    logic                 i_pix_valid;
    logic [FB_ADDR_W-1:0] i_pix_addr;
    color_idx_t           i_pix_color;
    depth_t               i_pix_depth;
    logic                 i_frame_clear;
    logic                 i_render_done;
    logic                 i_pal_we;
    color_idx_t           i_pal_idx;
    logic [PAL_W-1:0]     i_pal_data;
    logic                 o_render_ready;
    logic                 o_frame_swapped;
    logic                 o_hsync;
    logic                 o_vsync;
    logic                 o_de;
    logic [CHAN_W-1:0]    o_red;
    logic [CHAN_W-1:0]    o_green;
    logic [CHAN_W-1:0]    o_blue;

    // Reference model state
    color_idx_t           frame_m [2][FB_DEPTH];
    depth_t               depth_m [FB_DEPTH];
    logic [PAL_W-1:0]     pal_m [PAL_ENTRIES];
    bit                   render_sel_m;

    int                   seed;
    int                   errors;
    int                   checks;
    int                   done_count;
    int                   swap_pulses;
    int                   out_lines;
    int                   blank_cycles;
    logic                 prev_out_de;
    logic [31:0]          r;
    logic [FB_ADDR_W-1:0] addr;
    logic [FB_ADDR_W-1:0] prev_addr;

    display_top i_dut (
        .clk             (clk),
        .rstn            (rstn),
        .i_pix_valid     (i_pix_valid),
        .i_pix_addr      (i_pix_addr),
        .i_pix_color     (i_pix_color),
        .i_pix_depth     (i_pix_depth),
        .i_frame_clear   (i_frame_clear),
        .i_render_done   (i_render_done),
        .i_pal_we        (i_pal_we),
        .i_pal_idx       (i_pal_idx),
        .i_pal_data      (i_pal_data),
        .o_render_ready  (o_render_ready),
        .o_frame_swapped (o_frame_swapped),
        .o_hsync         (o_hsync),
        .o_vsync         (o_vsync),
        .o_de            (o_de),
        .o_red           (o_red),
        .o_green         (o_green),
        .o_blue          (o_blue)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the tests did not finish in time");
        $display("Done: errors found");
        $finish;
    end

    // Output raster position seen at each swap pulse
    always @(negedge clk) begin
        if (!rstn) begin
            out_lines    = 0;
            blank_cycles = 0;
            prev_out_de  = 1'b0;
        end else begin
            if (o_vsync) begin
                out_lines = 0;
            end else if (prev_out_de && !o_de) begin
                out_lines++;
            end
            blank_cycles = o_de ? 0 : blank_cycles + 1;
            prev_out_de  = o_de;
            // Three cycles after blanking starts, so the output sits at the end of the last line
            if (o_frame_swapped) begin
                swap_pulses++;
                check_value("swap after active lines", V_ACTIVE, 32'(out_lines));
                check_value("swap blank cycles", H_TOTAL - H_ACTIVE, 32'(blank_cycles));
            end
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERROR %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // Colour of one output pixel from the stored frame and palette
    function automatic logic [PAL_W-1:0] expected_pixel(input bit disp, input int x, input int y);
        int idx;
        if (x >= FB_WIDTH * SCALE || y >= FB_HEIGHT * SCALE) begin
            return '0;
        end
        idx = (y / SCALE) * FB_WIDTH + x / SCALE;
        return pal_m[frame_m[disp][FB_ADDR_W'(idx)]];
    endfunction

    task automatic drive_pixel(input logic [FB_ADDR_W-1:0] a, input color_idx_t color,
                               input depth_t depth);
        @(posedge clk);
        i_pix_valid <= 1'b1;
        i_pix_addr  <= a;
        i_pix_color <= color;
        i_pix_depth <= depth;
        // Strictly nearer pixels win
        if (depth < depth_m[a]) begin
            depth_m[a]                = depth;
            frame_m[render_sel_m][a]  = color;
        end
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        i_pix_valid <= 1'b0;
    endtask

    task automatic write_palette(input color_idx_t idx, input logic [PAL_W-1:0] data);
        @(posedge clk);
        i_pal_we   <= 1'b1;
        i_pal_idx  <= idx;
        i_pal_data <= data;
        pal_m[idx] = data;
        @(posedge clk);
        i_pal_we   <= 1'b0;
    endtask

    // Candidates offered during the sweep must all be dropped
    task automatic run_clear(input string name);
        int low_cycles;
        @(posedge clk);
        i_frame_clear <= 1'b1;
        @(posedge clk);
        i_frame_clear <= 1'b0;
        low_cycles = 0;
        for (int n = 0; n < FB_DEPTH + 16; n++) begin
            @(negedge clk);
            if (!o_render_ready) begin
                low_cycles++;
            end
            @(posedge clk);
            r = $random(seed);
            i_pix_valid <= (n < FB_DEPTH - 4);
            i_pix_addr  <= FB_ADDR_W'($unsigned(r) % FB_DEPTH);
            i_pix_color <= r[23:20];
            i_pix_depth <= '0;
        end
        check_value({name, " ready low cycles"}, FB_DEPTH, 32'(low_cycles));
        for (int n = 0; n < FB_DEPTH; n++) begin
            frame_m[render_sel_m][FB_ADDR_W'(n)] = '0;
            depth_m[FB_ADDR_W'(n)]               = '1;
        end
    endtask

    task automatic request_swap(input string name);
        int n;
        @(posedge clk);
        i_render_done <= 1'b1;
        @(posedge clk);
        i_render_done <= 1'b0;
        done_count++;
        n = 0;
        @(negedge clk);
        while (!o_frame_swapped && n < H_TOTAL * V_TOTAL + 8) begin
            n++;
            @(negedge clk);
        end
        if (!o_frame_swapped) begin
            errors++;
            $display("%s: no frame swap pulse within one frame", name);
        end else begin
            render_sel_m = ~render_sel_m;
        end
    endtask

    // Positions come from output de runs after the vsync pulse
    task automatic check_frame(input string name);
        int  x;
        int  y;
        int  vs_len;
        int  hs_len;
        bit  disp;
        logic prev_de;
        logic prev_hs;
        disp = ~render_sel_m;
        @(negedge clk);
        while (o_vsync) @(negedge clk);
        while (!o_vsync) @(negedge clk);
        vs_len = 0;
        while (o_vsync) begin
            vs_len++;
            @(negedge clk);
        end
        check_value({name, " vsync width"}, V_SYNC * H_TOTAL, 32'(vs_len));
        x       = 0;
        y       = 0;
        hs_len  = 0;
        prev_de = 1'b0;
        prev_hs = 1'b0;
        while (y < V_ACTIVE) begin
            if (o_de) begin
                check_value($sformatf("%s rgb at %0d,%0d", name, x, y),
                            32'(expected_pixel(disp, x, y)), 32'({o_red, o_green, o_blue}));
                x++;
            end else begin
                check_value({name, " blank rgb"}, 0, 32'({o_red, o_green, o_blue}));
                if (prev_de) begin
                    check_value({name, " line length"}, H_ACTIVE, 32'(x));
                    x = 0;
                    y++;
                end
            end
            if (o_hsync) begin
                hs_len++;
            end else if (prev_hs) begin
                check_value({name, " hsync width"}, H_SYNC, 32'(hs_len));
                hs_len = 0;
            end
            prev_de = o_de;
            prev_hs = o_hsync;
            @(negedge clk);
        end
    endtask

    initial begin
        seed          = 32'h5065_eb43;
        errors        = 0;
        checks        = 0;
        done_count    = 0;
        swap_pulses   = 0;
        render_sel_m  = 1'b0;
        rstn          = 1'b0;
        i_pix_valid   = 1'b0;
        i_pix_addr    = '0;
        i_pix_color   = '0;
        i_pix_depth   = '0;
        i_frame_clear = 1'b0;
        i_render_done = 1'b0;
        i_pal_we      = 1'b0;
        i_pal_idx     = '0;
        i_pal_data    = '0;
        for (int i = 0; i < PAL_ENTRIES; i++) begin
            pal_m[i] = '0;
        end

        repeat (15) @(posedge clk);
        @(negedge clk);
        check_value("reset swapped", 0, 32'(o_frame_swapped));
        check_value("reset sync", 0, 32'({o_hsync, o_vsync, o_de}));
        check_value("reset rgb", 0, 32'({o_red, o_green, o_blue}));
        check_value("reset ready", 1, 32'(o_render_ready));
        check_value("reset render_sel", 0, 32'(i_dut.render_sel));
        @(posedge clk);
        rstn <= 1'b1;

        // Both buffers get defined contents, palette still at reset
        run_clear("clear_a");
        request_swap("swap_1");
        run_clear("clear_b");
        check_frame("reset_palette");

        // Palette with a known index pattern
        for (int i = 0; i < PAL_ENTRIES; i++) begin
            write_palette(COLOR_IDX_W'(i), PAL_W'($random(seed)));
        end
        for (int a = 0; a < FB_DEPTH; a++) begin
            drive_pixel(FB_ADDR_W'(a), COLOR_IDX_W'((a * 5 + a / 16) % 16), 12'h800);
        end
        idle_cycle();
        request_swap("swap_2");
        check_frame("palette");

        // Depth test with repeated and back-to-back addresses
        run_clear("clear_depth");
        prev_addr = '0;
        for (int n = 0; n < 400; n++) begin
            r = $random(seed);
            if (r[2:0] == 3'd0) begin
                idle_cycle();
            end
            if (r[3] && n > 0) begin
                addr = prev_addr;
            end else if (r[4]) begin
                addr = FB_ADDR_W'(r[10:8]);
            end else begin
                addr = FB_ADDR_W'($unsigned($random(seed)) % FB_DEPTH);
            end
            drive_pixel(addr, r[15:12], r[27:16]);
            prev_addr = addr;
        end
        idle_cycle();
        check_frame("hidden_writes");
        request_swap("swap_3");
        check_frame("depth");

        run_clear("clear_swept");
        request_swap("swap_4");
        check_frame("cleared");

        repeat (4) @(negedge clk);
        check_value("swap pulse count", 32'(done_count), 32'(swap_pulses));
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: sim.f
disp_timing_pkg.sv
disp_pix_pkg.sv
video_timing.sv
pixel_ram.sv
depth_write.sv
frame_swap_ctrl.sv
palette_regs.sv
scan_out.sv
display_top.sv
tb_display.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the display testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_display -f sim.f -o tb_display && \
    ./obj_dir/tb_display | tee /dev/stderr | grep -qx "Done: no errors" && \
    echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
